// ==== source/video_gen_consts.svh ====
// video generator constants: small-mode raster timing, register numbers, reset defaults
`ifndef VIDEO_GEN_CONSTS_SVH
`define VIDEO_GEN_CONSTS_SVH

// horizontal timing in pixels with the offscreen part at the start of each line
`define VID_H_VISIBLE       32
`define VID_H_FRONT         4
`define VID_H_SYNC          6
`define VID_H_BACK          6
`define VID_H_OFFSCREEN     (`VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK)
`define VID_H_TOTAL         (`VID_H_OFFSCREEN + `VID_H_VISIBLE)

// vertical timing in lines with the visible lines at the top of each frame
`define VID_V_VISIBLE       6
`define VID_V_FRONT         1
`define VID_V_SYNC          2
`define VID_V_BACK          2
`define VID_V_TOTAL         (`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK)

// active sync levels (both active low)
`define VID_H_POL           1'b0
`define VID_V_POL           1'b0

// config register numbers
`define XR_VID_CTRL         5'h00
`define XR_VID_LEFT         5'h06
`define XR_VID_RIGHT        5'h07
`define XR_SCANLINE         5'h08
`define XR_VID_HSIZE        5'h0C
`define XR_VID_VSIZE        5'h0D
`define XR_PA_GFX_CTRL      5'h10

// dark grey border so a running but blanked display is visible
`define VID_BORDER_RESET    8'h08

`endif

// ==== source/video_gen_pkg.sv ====
// video generator package: width types, sync state encoding and shared structs
`default_nettype none

package video_gen_pkg;

    typedef logic [15:0] word_t;            // register data word
    typedef logic [4:0]  xreg_num_t;        // config register number
    typedef logic [9:0]  hres_t;            // horizontal pixel count
    typedef logic [9:0]  vres_t;            // vertical line count
    typedef logic [9:0]  hvis_t;            // column within the visible area
    typedef logic [7:0]  color_t;           // palette index
    typedef logic [3:0]  intr_t;            // interrupt bits

    // states step in this order, so a plain increment moves to the next one
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,
        SYNC      = 2'b01,
        POST_SYNC = 2'b10,
        VISIBLE   = 2'b11
    } video_state_t;

    // configuration seen by the pixel stage
    typedef struct packed {
        color_t border;                     // colour outside the window
        hvis_t  left;                       // first column inside the window
        hvis_t  right;                      // first column past the window
        color_t base;                       // solid colour inside the window
        logic   blank;                      // playfield off so the border fills the line
    } vid_cfg_t;

    // where the beam will be on the next cycle
    typedef struct packed {
        hvis_t x;                           // visible column
        logic  de;                          // display enable
    } scan_pos_t;

endpackage

`default_nettype wire

// ==== source/video_timing.sv ====
// video timing: horizontal/vertical sync FSMs, pixel and line counters, sync and DE outputs
`default_nettype none

`include "video_gen_consts.svh"

module video_timing (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    output video_gen_pkg::hres_t        h_count_o,              // pixel within line
    output video_gen_pkg::vres_t        v_count_o,              // line within frame
    output logic                        h_visible_o,            // current pixel in visible span
    output logic                        v_visible_o,            // current line in visible span
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o,
    output logic                        last_visible_pixel_o,   // final pixel of the visible frame
    output video_gen_pkg::scan_pos_t    scan_next_o             // beam position one cycle ahead
);

    video_gen_pkg::video_state_t    h_state;
    video_gen_pkg::video_state_t    h_state_next;
    video_gen_pkg::video_state_t    v_state;
    video_gen_pkg::video_state_t    v_state_next;
    video_gen_pkg::hres_t           h_end;          // last count of current h state
    video_gen_pkg::vres_t           v_end;          // last line of current v state
    video_gen_pkg::hres_t           h_count_next;
    video_gen_pkg::vres_t           v_count_next;
    logic                           line_end;
    logic                           frame_end;

    always_comb begin
        case (h_state)
            video_gen_pkg::PRE_SYNC:  h_end = video_gen_pkg::hres_t'(`VID_H_FRONT - 1);
            video_gen_pkg::SYNC:      h_end = video_gen_pkg::hres_t'(`VID_H_FRONT + `VID_H_SYNC - 1);
            video_gen_pkg::POST_SYNC: h_end = video_gen_pkg::hres_t'(`VID_H_OFFSCREEN - 1);
            default:                  h_end = video_gen_pkg::hres_t'(`VID_H_TOTAL - 1);
        endcase
    end

    // blanking lines sit below the visible lines
    always_comb begin
        case (v_state)
            video_gen_pkg::VISIBLE:   v_end = video_gen_pkg::vres_t'(`VID_V_VISIBLE - 1);
            video_gen_pkg::PRE_SYNC:  v_end = video_gen_pkg::vres_t'(`VID_V_VISIBLE + `VID_V_FRONT - 1);
            video_gen_pkg::SYNC:
                v_end = video_gen_pkg::vres_t'(`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC - 1);
            default:                  v_end = video_gen_pkg::vres_t'(`VID_V_TOTAL - 1);
        endcase
    end

    always_comb begin
        line_end  = (h_state == video_gen_pkg::VISIBLE) && (h_count_o == h_end);
        frame_end = line_end && (v_state == video_gen_pkg::POST_SYNC) && (v_count_o == v_end);

        h_state_next = h_state;
        if (h_count_o == h_end) begin
            h_state_next = video_gen_pkg::video_state_t'(h_state + 2'd1);  // VISIBLE wraps to PRE_SYNC
        end
        v_state_next = v_state;
        if (line_end && (v_count_o == v_end)) begin
            v_state_next = video_gen_pkg::video_state_t'(v_state + 2'd1);
        end

        h_count_next = line_end ? '0 : h_count_o + 1'b1;
        v_count_next = v_count_o;
        if (frame_end) begin
            v_count_next = '0;
        end else if (line_end) begin
            v_count_next = v_count_o + 1'b1;
        end
    end

    always_comb begin
        last_visible_pixel_o = line_end && (v_state == video_gen_pkg::VISIBLE) && (v_count_o == v_end);
        h_visible_o          = (h_state == video_gen_pkg::VISIBLE);
        v_visible_o          = (v_state == video_gen_pkg::VISIBLE);
        scan_next_o.x  = video_gen_pkg::hvis_t'(h_count_next - video_gen_pkg::hres_t'(`VID_H_OFFSCREEN));
        scan_next_o.de = (h_state_next == video_gen_pkg::VISIBLE) &&
                         (v_state_next == video_gen_pkg::VISIBLE);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state   <= video_gen_pkg::PRE_SYNC;
            v_state   <= video_gen_pkg::VISIBLE;        // first frame starts at the top
            h_count_o <= '0;
            v_count_o <= '0;
            hsync_o   <= ~`VID_H_POL;
            vsync_o   <= ~`VID_V_POL;
            dv_de_o   <= 1'b0;
        end else begin
            h_state   <= h_state_next;
            v_state   <= v_state_next;
            h_count_o <= h_count_next;
            v_count_o <= v_count_next;
            // outputs take the next state so they line up with the counters
            hsync_o   <= (h_state_next == video_gen_pkg::SYNC) ? `VID_H_POL : ~`VID_H_POL;
            vsync_o   <= (v_state_next == video_gen_pkg::SYNC) ? `VID_V_POL : ~`VID_V_POL;
            dv_de_o   <= scan_next_o.de;
        end
    end

    // hsync must fall entirely inside horizontal blanking
    a_no_de_in_hsync: assert property (@(posedge clk) disable iff (reset_i)
        !(dv_de_o && (hsync_o == `VID_H_POL)));

    a_h_count_range: assert property (@(posedge clk) disable iff (reset_i)
        h_count_o < video_gen_pkg::hres_t'(`VID_H_TOTAL));

endmodule

`default_nettype wire

// ==== source/video_regs.sv ====
// video config registers: write decode, registered readback and interrupt pulses
`default_nettype none

`include "video_gen_consts.svh"

module video_regs (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_en_i,        // one cycle write strobe
    input  wire video_gen_pkg::xreg_num_t   reg_num_i,          // for writes and reads
    input  wire video_gen_pkg::word_t       reg_data_i,
    input  wire video_gen_pkg::intr_t       intr_status_i,      // pending interrupts
    input  wire video_gen_pkg::vres_t       v_count_i,
    input  wire logic                       h_visible_i,
    input  wire logic                       v_visible_i,
    input  wire logic                       last_visible_pixel_i,
    output video_gen_pkg::word_t            reg_data_o,
    output video_gen_pkg::intr_t            intr_signal_o,      // single cycle pulses
    output video_gen_pkg::vid_cfg_t         cfg_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o <= '0;
            cfg_o.border  <= `VID_BORDER_RESET;
            cfg_o.left    <= '0;
            cfg_o.right   <= video_gen_pkg::hvis_t'(`VID_H_VISIBLE);   // window spans full width
            cfg_o.base    <= '0;
            cfg_o.blank   <= 1'b1;                                   // come up blanked
        end else begin
            intr_signal_o <= '0;
            if (reg_wr_en_i) begin
                case (reg_num_i)
                    `XR_VID_CTRL: begin
                        cfg_o.border  <= reg_data_i[15:8];
                        intr_signal_o <= reg_data_i[3:0];           // software raised interrupts
                    end
                    `XR_VID_LEFT: begin
                        cfg_o.left <= reg_data_i[9:0];
                    end
                    `XR_VID_RIGHT: begin
                        cfg_o.right <= reg_data_i[9:0];
                    end
                    `XR_PA_GFX_CTRL: begin
                        cfg_o.base  <= reg_data_i[15:8];
                        cfg_o.blank <= reg_data_i[7];
                    end
                    default: begin
                    end
                endcase
            end
            // end of visible frame interrupt
            if (last_visible_pixel_i) begin
                intr_signal_o[3] <= 1'b1;
            end
        end
    end

    // readback runs every cycle whether or not a read is pending
    always_ff @(posedge clk) begin
        case (reg_num_i)
            `XR_VID_CTRL:    reg_data_o <= {cfg_o.border, 4'b0, intr_status_i};
            `XR_VID_LEFT:    reg_data_o <= 16'(cfg_o.left);
            `XR_VID_RIGHT:   reg_data_o <= 16'(cfg_o.right);
            `XR_SCANLINE:    reg_data_o <= {~v_visible_i, ~h_visible_i, 14'(v_count_i)};
            `XR_VID_HSIZE:   reg_data_o <= 16'(`VID_H_VISIBLE);
            `XR_VID_VSIZE:   reg_data_o <= 16'(`VID_V_VISIBLE);
            `XR_PA_GFX_CTRL: reg_data_o <= {cfg_o.base, cfg_o.blank, 7'b0};
            default:         reg_data_o <= '0;
        endcase
    end

    a_intr_quiet_after_reset: assert property (@(posedge clk)
        reset_i |=> (intr_signal_o == '0));

endmodule

`default_nettype wire

// ==== source/video_window.sv ====
// pixel stage: border colour outside the left/right window, base colour inside it
`default_nettype none

module video_window (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire video_gen_pkg::scan_pos_t   scan_next_i,    // position for the next cycle
    input  wire video_gen_pkg::vid_cfg_t    cfg_i,
    output video_gen_pkg::color_t           color_index_o
);

    logic in_window;

    // right edge is exclusive
    always_comb begin
        in_window = (scan_next_i.x >= cfg_i.left) &&
                    (scan_next_i.x < cfg_i.right) &&
                    !cfg_i.blank;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= '0;
        end else if (!scan_next_i.de) begin
            color_index_o <= '0;                // black during blanking
        end else if (in_window) begin
            color_index_o <= cfg_i.base;
        end else begin
            color_index_o <= cfg_i.border;
        end
    end

endmodule

`default_nettype wire

// ==== source/video_gen.sv ====
// video generator top: ties together the timing, register and pixel window blocks
`default_nettype none

module video_gen (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_en_i,
    input  wire video_gen_pkg::xreg_num_t   reg_num_i,
    input  wire video_gen_pkg::word_t       reg_data_i,
    output video_gen_pkg::word_t            reg_data_o,
    input  wire video_gen_pkg::intr_t       intr_status_i,
    output video_gen_pkg::intr_t            intr_signal_o,
    output video_gen_pkg::hres_t            h_count_o,
    output video_gen_pkg::vres_t            v_count_o,
    output logic                            hsync_o,
    output logic                            vsync_o,
    output logic                            dv_de_o,
    output video_gen_pkg::color_t           color_index_o
);

    video_gen_pkg::scan_pos_t   scan_next;
    video_gen_pkg::vid_cfg_t    cfg;
    logic                       h_visible;
    logic                       v_visible;
    logic                       last_visible_pixel;

    video_timing u_timing (
        .clk                    (clk),
        .reset_i                (reset_i),
        .h_count_o              (h_count_o),
        .v_count_o              (v_count_o),
        .h_visible_o            (h_visible),
        .v_visible_o            (v_visible),
        .hsync_o                (hsync_o),
        .vsync_o                (vsync_o),
        .dv_de_o                (dv_de_o),
        .last_visible_pixel_o   (last_visible_pixel),
        .scan_next_o            (scan_next)
    );

    video_regs u_regs (
        .clk                    (clk),
        .reset_i                (reset_i),
        .reg_wr_en_i            (reg_wr_en_i),
        .reg_num_i              (reg_num_i),
        .reg_data_i             (reg_data_i),
        .intr_status_i          (intr_status_i),
        .v_count_i              (v_count_o),
        .h_visible_i            (h_visible),
        .v_visible_i            (v_visible),
        .last_visible_pixel_i   (last_visible_pixel),
        .reg_data_o             (reg_data_o),
        .intr_signal_o          (intr_signal_o),
        .cfg_o                  (cfg)
    );

    video_window u_window (
        .clk                    (clk),
        .reset_i                (reset_i),
        .scan_next_i            (scan_next),
        .cfg_i                  (cfg),
        .color_index_o          (color_index_o)
    );

endmodule

`default_nettype wire

// ==== verification/video_gen_tb.sv ====
// video generator testbench: random register traffic checked against a cycle model
`default_nettype none

`include "video_gen_consts.svh"

module video_gen_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES   = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int RESET_CYCLES   = 4;
    localparam int RESET_READS    = 6;
    localparam int SYNC_CYCLES    = 2 * FRAME_CYCLES;
    localparam int REG_PAIRS      = 300;                // write cycle then read cycle
    localparam int PIXEL_CYCLES   = 2 * FRAME_CYCLES;
    localparam int INTR_CYCLES    = FRAME_CYCLES + 64;
    localparam int TEST_CYCLES    = RESET_CYCLES + RESET_READS + SYNC_CYCLES + 2 * REG_PAIRS +
                                    PIXEL_CYCLES + INTR_CYCLES;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + FRAME_CYCLES;    // one spare frame

    logic                       clk;
    logic                       reset;
    logic                       reg_wr_en;
    video_gen_pkg::xreg_num_t   reg_num;
    video_gen_pkg::word_t       wr_data;
    video_gen_pkg::word_t       rd_data;
    video_gen_pkg::intr_t       intr_status;
    video_gen_pkg::intr_t       intr_signal;
    video_gen_pkg::hres_t       h_count;
    video_gen_pkg::vres_t       v_count;
    logic                       hsync;
    logic                       vsync;
    logic                       dv_de;
    video_gen_pkg::color_t      color_index;

    integer                     seed;
    int                         errors;
    int                         checks;
    int                         cycle_count;
    string                      test_name;

    // reference model state
    int                         m_n;                // cycles since reset
    int                         m_h;
    int                         m_v;
    video_gen_pkg::vid_cfg_t    m_cfg;
    video_gen_pkg::word_t       exp_rd_data;
    video_gen_pkg::intr_t       exp_intr;
    video_gen_pkg::color_t      exp_color;

    video_gen uut (
        .clk            (clk),
        .reset_i        (reset),
        .reg_wr_en_i    (reg_wr_en),
        .reg_num_i      (reg_num),
        .reg_data_i     (wr_data),
        .reg_data_o     (rd_data),
        .intr_status_i  (intr_status),
        .intr_signal_o  (intr_signal),
        .h_count_o      (h_count),
        .v_count_o      (v_count),
        .hsync_o        (hsync),
        .vsync_o        (vsync),
        .dv_de_o        (dv_de),
        .color_index_o  (color_index)
    );

    always #20 clk = ~clk;                          // 40 ns period

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: simulation still running after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic video_gen_pkg::video_state_t h_state_of(input int h);
        video_gen_pkg::video_state_t state;
        if (h < `VID_H_FRONT) begin
            state = video_gen_pkg::PRE_SYNC;
        end else if (h < `VID_H_FRONT + `VID_H_SYNC) begin
            state = video_gen_pkg::SYNC;
        end else if (h < `VID_H_OFFSCREEN) begin
            state = video_gen_pkg::POST_SYNC;
        end else begin
            state = video_gen_pkg::VISIBLE;
        end
        return state;
    endfunction

    // visible lines first, then front porch, sync and back porch
    function automatic video_gen_pkg::video_state_t v_state_of(input int v);
        video_gen_pkg::video_state_t state;
        if (v < `VID_V_VISIBLE) begin
            state = video_gen_pkg::VISIBLE;
        end else if (v < `VID_V_VISIBLE + `VID_V_FRONT) begin
            state = video_gen_pkg::PRE_SYNC;
        end else if (v < `VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC) begin
            state = video_gen_pkg::SYNC;
        end else begin
            state = video_gen_pkg::POST_SYNC;
        end
        return state;
    endfunction

    function automatic video_gen_pkg::word_t expected_readback(
        input video_gen_pkg::xreg_num_t num,
        input video_gen_pkg::intr_t     status
    );
        video_gen_pkg::word_t value;
        value = '0;
        case (num)
            `XR_VID_CTRL:    value = {m_cfg.border, 4'h0, status};
            `XR_VID_LEFT:    value[9:0] = m_cfg.left;
            `XR_VID_RIGHT:   value[9:0] = m_cfg.right;
            `XR_SCANLINE: begin
                value[15]   = (m_v >= `VID_V_VISIBLE);          // vertical blanking
                value[14]   = (m_h < `VID_H_OFFSCREEN);         // horizontal blanking
                value[13:0] = 14'(m_v);
            end
            `XR_VID_HSIZE:   value = 16'(`VID_H_VISIBLE);
            `XR_VID_VSIZE:   value = 16'(`VID_V_VISIBLE);
            `XR_PA_GFX_CTRL: value = {m_cfg.base, m_cfg.blank, 7'h00};
            default:         value = '0;
        endcase
        return value;
    endfunction

    task automatic reset_model();
        m_n          = 0;
        m_h          = 0;
        m_v          = 0;
        m_cfg.border = `VID_BORDER_RESET;
        m_cfg.left   = '0;
        m_cfg.right  = 10'(`VID_H_VISIBLE);
        m_cfg.base   = '0;
        m_cfg.blank  = 1'b1;
        exp_intr     = '0;
        exp_color    = '0;
    endtask

    // advance the model by one clock edge with the inputs sampled there
    task automatic model_edge(
        input logic                     wr,
        input video_gen_pkg::xreg_num_t num,
        input video_gen_pkg::word_t     data,
        input video_gen_pkg::intr_t     status
    );
        int   h_next;
        int   v_next;
        int   x;
        logic de;
        h_next = (m_n + 1) % `VID_H_TOTAL;
        v_next = ((m_n + 1) / `VID_H_TOTAL) % `VID_V_TOTAL;
        exp_rd_data = expected_readback(num, status);
        exp_intr = '0;
        if (wr && (num == `XR_VID_CTRL)) begin
            exp_intr = data[3:0];
        end
        if ((m_h == `VID_H_TOTAL - 1) && (m_v == `VID_V_VISIBLE - 1)) begin
            exp_intr[3] = 1'b1;                         // end of visible frame
        end
        de = (h_next >= `VID_H_OFFSCREEN) && (v_next < `VID_V_VISIBLE);
        x  = h_next - `VID_H_OFFSCREEN;
        if (!de) begin
            exp_color = '0;
        end else if (!m_cfg.blank && (x >= int'(m_cfg.left)) && (x < int'(m_cfg.right))) begin
            exp_color = m_cfg.base;
        end else begin
            exp_color = m_cfg.border;
        end
        if (wr) begin
            case (num)
                `XR_VID_CTRL:    m_cfg.border = data[15:8];
                `XR_VID_LEFT:    m_cfg.left = data[9:0];
                `XR_VID_RIGHT:   m_cfg.right = data[9:0];
                `XR_PA_GFX_CTRL: begin
                    m_cfg.base  = data[15:8];
                    m_cfg.blank = data[7];
                end
                default: begin
                end
            endcase
        end
        m_n = m_n + 1;
        m_h = h_next;
        m_v = v_next;
    endtask

    task automatic compare_value(
        input string       signal_name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("MISMATCH %s %s: expected %0h, actual %0h (h=%0d v=%0d)",
                     test_name, signal_name, expected, actual, m_h, m_v);
        end
    endtask

    task automatic check_timing();
        logic exp_hsync;
        logic exp_vsync;
        logic exp_de;
        exp_hsync = (h_state_of(m_h) == video_gen_pkg::SYNC) ? `VID_H_POL : ~`VID_H_POL;
        exp_vsync = (v_state_of(m_v) == video_gen_pkg::SYNC) ? `VID_V_POL : ~`VID_V_POL;
        exp_de    = (h_state_of(m_h) == video_gen_pkg::VISIBLE) &&
                    (v_state_of(m_v) == video_gen_pkg::VISIBLE);
        compare_value("h_count", 32'(m_h), 32'(h_count));
        compare_value("v_count", 32'(m_v), 32'(v_count));
        compare_value("hsync", 32'(exp_hsync), 32'(hsync));
        compare_value("vsync", 32'(exp_vsync), 32'(vsync));
        compare_value("dv_de", 32'(exp_de), 32'(dv_de));
    endtask

    // drive one set of inputs, clock it in and check everything afterwards
    task automatic run_cycle(
        input logic                     wr,
        input video_gen_pkg::xreg_num_t num,
        input video_gen_pkg::word_t     data,
        input video_gen_pkg::intr_t     status
    );
        reg_wr_en   = wr;
        reg_num     = num;
        wr_data     = data;
        intr_status = status;
        @(posedge clk);
        model_edge(wr, num, data, status);
        #5;
        check_timing();
        compare_value("reg_data", 32'(exp_rd_data), 32'(rd_data));
        compare_value("intr_signal", 32'(exp_intr), 32'(intr_signal));
        compare_value("color_index", 32'(exp_color), 32'(color_index));
    endtask

    task automatic read_reset_value(
        input video_gen_pkg::xreg_num_t num,
        input video_gen_pkg::word_t     expected
    );
        run_cycle(1'b0, num, '0, '0);
        compare_value("reset readback", 32'(expected), 32'(rd_data));
    endtask

    task automatic check_reset_state();
        test_name = "reset";
        check_timing();
        compare_value("intr_signal", 32'h0, 32'(intr_signal));
        read_reset_value(`XR_VID_CTRL, 16'h0800);
        read_reset_value(`XR_VID_RIGHT, 16'd32);
        read_reset_value(`XR_VID_HSIZE, 16'd32);
        read_reset_value(`XR_VID_VSIZE, 16'd6);
        read_reset_value(`XR_PA_GFX_CTRL, 16'h0080);
        read_reset_value(`XR_VID_LEFT, 16'h0000);
    endtask

    task automatic run_sync_test();
        logic [31:0] r;
        test_name = "counters and sync";
        repeat (SYNC_CYCLES) begin
            r = $random(seed);
            run_cycle(1'b0, r[4:0], r[31:16], r[11:8]);     // reads only
        end
    endtask

    task automatic run_reg_test();
        logic [31:0] r;
        logic [31:0] d;
        test_name = "register readback";
        repeat (REG_PAIRS) begin
            r = $random(seed);
            d = $random(seed);
            run_cycle(1'b1, r[4:0], d[15:0], r[11:8]);
            run_cycle(1'b0, r[4:0], '0, r[15:12]);
        end
    endtask

    task automatic run_pixel_test();
        logic [31:0]              r;
        logic [31:0]              d;
        video_gen_pkg::xreg_num_t num;
        test_name = "pixel colour";
        repeat (PIXEL_CYCLES) begin
            r = $random(seed);
            d = $random(seed);
            case (r[6:5])
                2'd0:    num = `XR_VID_CTRL;
                2'd1:    num = `XR_VID_LEFT;
                2'd2:    num = `XR_VID_RIGHT;
                default: num = `XR_PA_GFX_CTRL;
            endcase
            if (num == `XR_VID_LEFT || num == `XR_VID_RIGHT) begin
                d[9:0] = 10'(d[15:10] % 40);            // edges a little past the width
            end
            run_cycle(r[3:0] == 4'h0, num, d[15:0], r[11:8]);
        end
    endtask

    task automatic run_intr_test();
        logic [31:0] r;
        logic [31:0] d;
        test_name = "interrupts";
        repeat (INTR_CYCLES) begin
            r = $random(seed);
            d = $random(seed);
            run_cycle(r[4:0] < 5'd2, `XR_VID_CTRL, d[15:0], r[11:8]);
        end
    endtask

    initial begin
        seed        = 32'hdd3a053a;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        test_name   = "reset";
        clk         = 1'b0;
        reset       = 1'b1;
        reg_wr_en   = 1'b0;
        reg_num     = '0;
        wr_data     = '0;
        intr_status = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b0;
        check_reset_state();
        run_sync_test();
        run_reg_test();
        run_pixel_test();
        run_intr_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== video_gen.f ====
+incdir+source
source/video_gen_pkg.sv
source/video_timing.sv
source/video_regs.sv
source/video_window.sv
source/video_gen.sv
verification/video_gen_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f video_gen.f \
		--top-module video_gen_tb -Mdir obj_dir
	./obj_dir/Vvideo_gen_tb | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
